// ==== hdl/yaw_pkg.sv ====
package yaw_pkg;

	// Receiver values are 8 bits wide
	localparam int REC_WIDTH = 8;

	// Angles, errors and the normalized stick are signed 12.4 fixed point
	localparam int RATE_WIDTH = 16;

	// Extra fraction bits carried by the tracked target angle
	localparam int SCALE_BITS = 2;

	// 16 counts per degree, so a full turn is 5760 counts
	localparam logic signed [RATE_WIDTH-1:0] ANGLE_360 = 16'sd5760;
	localparam logic signed [RATE_WIDTH-1:0] ANGLE_270 = 16'sd4320;
	localparam logic signed [RATE_WIDTH-1:0] ANGLE_90  = 16'sd1440;

	// Full turn in the scaled domain of the tracked angle, 23040 counts
	localparam logic signed [RATE_WIDTH-1:0] ANGLE_360_SCALED = ANGLE_360 <<< SCALE_BITS;

	// Throttle below this is treated as motors idle
	localparam logic [REC_WIDTH-1:0] THROTTLE_IDLE_MAX = 8'd10;

	// Stick counts as neutral when strictly inside +/- this value
	localparam logic signed [RATE_WIDTH-1:0] NEUTRAL_HALF_WINDOW = 16'sd4;

	// Largest change of the yaw error from one run to the next (about 3 degrees)
	localparam logic signed [RATE_WIDTH-1:0] ERROR_MAX_CHANGE = 16'sd50;

	// One step per clock while a run is active
	typedef enum logic [3:0] {
		STEP_INIT,
		STEP_WAIT,
		STEP_LATCH,
		STEP_NEUTRAL,
		STEP_NORMALIZE,
		STEP_WINDOW,
		STEP_TRACK_SUM,
		STEP_TRACK_WRAP,
		STEP_TARGET,
		STEP_ERROR_DIFF,
		STEP_ERROR_WRAP,
		STEP_RATE_LIMIT,
		STEP_OUTPUT,
		STEP_COMPLETE
	} yaw_step_e;

endpackage

// ==== hdl/yaw_sequencer.sv ====
`timescale 1ns/1ps

module yaw_sequencer (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              start_signal,
	output yaw_pkg::yaw_step_e step,
	output logic              active_signal,
	output logic              complete_signal
);

	yaw_pkg::yaw_step_e step_next;
	logic               start_flag;

	// Start is held until the run has left the wait step and the strobe has dropped
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start_signal) begin
			start_flag <= 1'b1;
		end else if (step != yaw_pkg::STEP_WAIT) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			step <= yaw_pkg::STEP_INIT;
		end else begin
			step <= step_next;
		end
	end

	// Fixed run sequence, one step per cycle
	always_comb begin
		case (step)
			yaw_pkg::STEP_INIT:       step_next = yaw_pkg::STEP_WAIT;
			yaw_pkg::STEP_WAIT: begin
				if (start_flag) begin
					step_next = yaw_pkg::STEP_LATCH;
				end else begin
					step_next = yaw_pkg::STEP_WAIT;
				end
			end
			yaw_pkg::STEP_LATCH:      step_next = yaw_pkg::STEP_NEUTRAL;
			yaw_pkg::STEP_NEUTRAL:    step_next = yaw_pkg::STEP_NORMALIZE;
			yaw_pkg::STEP_NORMALIZE:  step_next = yaw_pkg::STEP_WINDOW;
			yaw_pkg::STEP_WINDOW:     step_next = yaw_pkg::STEP_TRACK_SUM;
			yaw_pkg::STEP_TRACK_SUM:  step_next = yaw_pkg::STEP_TRACK_WRAP;
			yaw_pkg::STEP_TRACK_WRAP: step_next = yaw_pkg::STEP_TARGET;
			yaw_pkg::STEP_TARGET:     step_next = yaw_pkg::STEP_ERROR_DIFF;
			yaw_pkg::STEP_ERROR_DIFF: step_next = yaw_pkg::STEP_ERROR_WRAP;
			yaw_pkg::STEP_ERROR_WRAP: step_next = yaw_pkg::STEP_RATE_LIMIT;
			yaw_pkg::STEP_RATE_LIMIT: step_next = yaw_pkg::STEP_OUTPUT;
			yaw_pkg::STEP_OUTPUT:     step_next = yaw_pkg::STEP_COMPLETE;
			yaw_pkg::STEP_COMPLETE:   step_next = yaw_pkg::STEP_WAIT;
			// Unused encodings recover through init
			default:                  step_next = yaw_pkg::STEP_INIT;
		endcase
	end

	// Handshake levels lag the step by one cycle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			active_signal   <= 1'b0;
			complete_signal <= 1'b0;
		end else begin
			complete_signal <= (step == yaw_pkg::STEP_COMPLETE);
			active_signal   <= step inside {
				yaw_pkg::STEP_LATCH,
				yaw_pkg::STEP_NEUTRAL,
				yaw_pkg::STEP_NORMALIZE,
				yaw_pkg::STEP_WINDOW,
				yaw_pkg::STEP_TRACK_SUM,
				yaw_pkg::STEP_TRACK_WRAP,
				yaw_pkg::STEP_TARGET,
				yaw_pkg::STEP_ERROR_DIFF,
				yaw_pkg::STEP_ERROR_WRAP,
				yaw_pkg::STEP_RATE_LIMIT,
				yaw_pkg::STEP_OUTPUT
			};
		end
	end

endmodule

// ==== hdl/yaw_stick_tracker.sv ====
`timescale 1ns/1ps

module yaw_stick_tracker (
	input  logic                                    us_clk,
	input  logic                                    resetn,
	input  yaw_pkg::yaw_step_e                      step,
	input  logic        [yaw_pkg::REC_WIDTH-1:0]    throttle_pwm_value_input,
	input  logic        [yaw_pkg::REC_WIDTH-1:0]    yaw_pwm_value_input,
	input  logic signed [yaw_pkg::RATE_WIDTH-1:0]   yaw_angle_imu,
	output logic                                    throttle_idle,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0]   imu_latched,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0]   stick_latched,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0]   track_target,
	output logic                                    yaw_stick_out_of_neutral_window
);

	localparam int PAD_WIDTH = yaw_pkg::RATE_WIDTH - yaw_pkg::REC_WIDTH;

	logic        [yaw_pkg::REC_WIDTH-1:0]  throttle_latched;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] neutral_value;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] stick_normalized;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] track_sum;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] track_angle;
	logic                                  stick_in_window;

	assign throttle_idle = (throttle_latched < yaw_pkg::THROTTLE_IDLE_MAX);

	assign stick_in_window = (stick_normalized < yaw_pkg::NEUTRAL_HALF_WINDOW) &&
		(stick_normalized > -yaw_pkg::NEUTRAL_HALF_WINDOW);

	// Snapshot of the inputs for this run
	always_ff @(posedge us_clk) begin
		if (step == yaw_pkg::STEP_LATCH) begin
			throttle_latched <= throttle_pwm_value_input;
			stick_latched    <= {{PAD_WIDTH{1'b0}}, yaw_pwm_value_input};
			imu_latched      <= yaw_angle_imu;
		end
	end

	// Intermediate values, only meaningful inside a run
	always_ff @(posedge us_clk) begin
		case (step)
			yaw_pkg::STEP_NORMALIZE: begin
				stick_normalized <= stick_latched - neutral_value;
			end
			yaw_pkg::STEP_TRACK_SUM: begin
				track_sum <= track_angle + stick_normalized;
			end
			default: begin
			end
		endcase
	end

	// Neutral stick is learned only while the motors are idle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			neutral_value <= '0;
		end else if (step == yaw_pkg::STEP_NEUTRAL && throttle_idle) begin
			neutral_value <= stick_latched;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_stick_out_of_neutral_window <= 1'b0;
		end else if (step == yaw_pkg::STEP_WINDOW) begin
			yaw_stick_out_of_neutral_window <= !throttle_idle && !stick_in_window;
		end
	end

	// Tracked angle is kept with SCALE_BITS extra fraction bits
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_angle <= '0;
		end else if (step == yaw_pkg::STEP_TRACK_WRAP) begin
			if (throttle_idle) begin
				// On the ground the target follows the IMU
				track_angle <= imu_latched <<< yaw_pkg::SCALE_BITS;
			end else if (yaw_stick_out_of_neutral_window) begin
				if (track_sum > yaw_pkg::ANGLE_360_SCALED) begin
					track_angle <= track_sum - yaw_pkg::ANGLE_360_SCALED;
				end else if (track_sum < 0) begin
					track_angle <= track_sum + yaw_pkg::ANGLE_360_SCALED;
				end else begin
					track_angle <= track_sum;
				end
			end
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_target <= '0;
		end else if (step == yaw_pkg::STEP_TARGET) begin
			if (throttle_idle) begin
				track_target <= imu_latched;
			end else begin
				track_target <= track_angle >>> yaw_pkg::SCALE_BITS;
			end
		end
	end

endmodule

// ==== hdl/yaw_error_limiter.sv ====
`timescale 1ns/1ps

module yaw_error_limiter (
	input  logic                                    us_clk,
	input  logic                                    resetn,
	input  yaw_pkg::yaw_step_e                      step,
	input  logic                                    yaac_enable_n,
	input  logic                                    throttle_idle,
	input  logic signed [yaw_pkg::RATE_WIDTH-1:0]   imu_latched,
	input  logic signed [yaw_pkg::RATE_WIDTH-1:0]   stick_latched,
	input  logic signed [yaw_pkg::RATE_WIDTH-1:0]   track_target,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0]   body_yaw_angle_target,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0]   yaw_angle_error_out
);

	logic signed [yaw_pkg::RATE_WIDTH-1:0] error_diff;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] error_wrapped;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] error_limited;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] error_prev;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] error_clamped;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] prev_low;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] prev_high;

	// Allowed band around last run's error
	assign prev_low  = error_prev - yaw_pkg::ERROR_MAX_CHANGE;
	assign prev_high = error_prev + yaw_pkg::ERROR_MAX_CHANGE;

	always_comb begin
		if (error_limited > yaw_pkg::ANGLE_90) begin
			error_clamped = yaw_pkg::ANGLE_90;
		end else if (error_limited < -yaw_pkg::ANGLE_90) begin
			error_clamped = -yaw_pkg::ANGLE_90;
		end else begin
			error_clamped = error_limited;
		end
	end

	always_ff @(posedge us_clk) begin
		case (step)
			yaw_pkg::STEP_ERROR_DIFF: begin
				error_diff <= track_target - imu_latched;
			end
			yaw_pkg::STEP_ERROR_WRAP: begin
				if (throttle_idle) begin
					error_wrapped <= '0;
				end else if (track_target > yaw_pkg::ANGLE_270 &&
						imu_latched < yaw_pkg::ANGLE_90) begin
					// Target just below 360, IMU just past 0
					error_wrapped <= -(yaw_pkg::ANGLE_360 - track_target + imu_latched);
				end else if (imu_latched > yaw_pkg::ANGLE_270 &&
						track_target < yaw_pkg::ANGLE_90) begin
					error_wrapped <= yaw_pkg::ANGLE_360 - imu_latched + track_target;
				end else begin
					error_wrapped <= error_diff;
				end
			end
			yaw_pkg::STEP_RATE_LIMIT: begin
				// Hold at the rail instead of flipping sign across +/-90
				if (error_prev >= yaw_pkg::ANGLE_90 &&
						error_wrapped <= -yaw_pkg::ANGLE_90) begin
					error_limited <= yaw_pkg::ANGLE_90;
				end else if (error_prev <= -yaw_pkg::ANGLE_90 &&
						error_wrapped >= yaw_pkg::ANGLE_90) begin
					error_limited <= -yaw_pkg::ANGLE_90;
				end else if (error_wrapped < prev_low) begin
					error_limited <= prev_low;
				end else if (error_wrapped > prev_high) begin
					error_limited <= prev_high;
				end else begin
					error_limited <= error_wrapped;
				end
			end
			default: begin
			end
		endcase
	end

	// Previous error is kept in bypass too, so enabling the unit starts smoothly
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			error_prev <= '0;
		end else if (step == yaw_pkg::STEP_OUTPUT) begin
			error_prev <= error_limited;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			body_yaw_angle_target <= '0;
			yaw_angle_error_out   <= '0;
		end else if (step == yaw_pkg::STEP_OUTPUT) begin
			if (yaac_enable_n) begin
				// Bypass passes the raw stick straight through
				body_yaw_angle_target <= stick_latched;
				yaw_angle_error_out   <= '0;
			end else begin
				body_yaw_angle_target <= track_target;
				yaw_angle_error_out   <= error_clamped;
			end
		end
	end

endmodule

// ==== hdl/yaw_angle_accumulator.sv ====
`timescale 1ns/1ps

module yaw_angle_accumulator (
	output logic signed [yaw_pkg::RATE_WIDTH-1:0] body_yaw_angle_target,
	output logic signed [yaw_pkg::RATE_WIDTH-1:0] yaw_angle_error_out,
	output logic                                  active_signal,
	output logic                                  complete_signal,
	output logic                                  yaw_stick_out_of_neutral_window,
	input  logic        [yaw_pkg::REC_WIDTH-1:0]  throttle_pwm_value_input,
	input  logic        [yaw_pkg::REC_WIDTH-1:0]  yaw_pwm_value_input,
	input  logic signed [yaw_pkg::RATE_WIDTH-1:0] yaw_angle_imu,
	input  logic                                  yaac_enable_n,
	input  logic                                  start_signal,
	input  logic                                  resetn,
	input  logic                                  us_clk
);

	yaw_pkg::yaw_step_e                    step;
	logic                                  throttle_idle;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] imu_latched;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] stick_latched;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] track_target;

	yaw_sequencer yaw_sequencer_i (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start_signal    (start_signal),
		.step            (step),
		.active_signal   (active_signal),
		.complete_signal (complete_signal)
	);

	yaw_stick_tracker yaw_stick_tracker_i (
		.us_clk                          (us_clk),
		.resetn                          (resetn),
		.step                            (step),
		.throttle_pwm_value_input        (throttle_pwm_value_input),
		.yaw_pwm_value_input             (yaw_pwm_value_input),
		.yaw_angle_imu                   (yaw_angle_imu),
		.throttle_idle                   (throttle_idle),
		.imu_latched                     (imu_latched),
		.stick_latched                   (stick_latched),
		.track_target                    (track_target),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window)
	);

	yaw_error_limiter yaw_error_limiter_i (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.step                  (step),
		.yaac_enable_n         (yaac_enable_n),
		.throttle_idle         (throttle_idle),
		.imu_latched           (imu_latched),
		.stick_latched         (stick_latched),
		.track_target          (track_target),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error_out   (yaw_angle_error_out)
	);

endmodule

// ==== test/yaw_angle_accumulator_assert.sv ====
`timescale 1ns/1ps

module yaw_angle_assert (
	input logic us_clk,
	input logic resetn,
	input logic start_signal,
	input logic active_signal,
	input logic complete_signal
);

	// Active drops on the edge where complete rises
	active_complete_exclusive: assert property (
		@(posedge us_clk) disable iff (!resetn)
		!(active_signal && complete_signal)
	) else $error("active and complete high in the same cycle");

	complete_single_cycle: assert property (
		@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal
	) else $error("complete held for more than one cycle");

	// Complete rises 13 edges after the edge that sampled start
	complete_after_start: assert property (
		@(posedge us_clk) disable iff (!resetn)
		$rose(complete_signal) |-> $past(start_signal, 14)
	) else $error("complete without a matching start");

endmodule

bind yaw_angle_accumulator yaw_angle_assert yaw_angle_assert_i (
	.us_clk          (us_clk),
	.resetn          (resetn),
	.start_signal    (start_signal),
	.active_signal   (active_signal),
	.complete_signal (complete_signal)
);

// ==== test/tb_yaw_angle_accumulator.sv ====
`timescale 1ns/1ps

module tb_yaw_angle_accumulator;

	// Runs per section: idle, neutral, wrap, near 0/360, rail, bypass, double start, random
	localparam int RUN_COUNT   = 5 + 7 + 14 + 20 + 48 + 5 + 2 + 200;
	localparam int CYCLE_LIMIT = 60 * RUN_COUNT;
	localparam int RUN_TIMEOUT = 20;

	// Active covers the steps from latch through output
	localparam int ACTIVE_CYCLES = 11;

	logic                                  us_clk;
	logic                                  resetn;
	logic                                  start_signal;
	logic                                  yaac_enable_n;
	logic        [yaw_pkg::REC_WIDTH-1:0]  throttle_pwm_value_input;
	logic        [yaw_pkg::REC_WIDTH-1:0]  yaw_pwm_value_input;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] yaw_angle_imu;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] body_yaw_angle_target;
	logic signed [yaw_pkg::RATE_WIDTH-1:0] yaw_angle_error_out;
	logic                                  active_signal;
	logic                                  complete_signal;
	logic                                  yaw_stick_out_of_neutral_window;

	// Reference state, mirrors the registers that live across runs
	int model_neutral;
	int model_track;
	int model_prev_error;

	int exp_target_q[$];
	int exp_error_q[$];
	bit exp_window_q[$];

	int error_count;
	int check_count;
	int complete_count;
	int cycle_count;
	int active_cycles;

	yaw_angle_accumulator yaw_angle_accumulator_i (
		.body_yaw_angle_target           (body_yaw_angle_target),
		.yaw_angle_error_out             (yaw_angle_error_out),
		.active_signal                   (active_signal),
		.complete_signal                 (complete_signal),
		.yaw_stick_out_of_neutral_window (yaw_stick_out_of_neutral_window),
		.throttle_pwm_value_input        (throttle_pwm_value_input),
		.yaw_pwm_value_input             (yaw_pwm_value_input),
		.yaw_angle_imu                   (yaw_angle_imu),
		.yaac_enable_n                   (yaac_enable_n),
		.start_signal                    (start_signal),
		.resetn                          (resetn),
		.us_clk                          (us_clk)
	);

	initial us_clk = 1'b0;

	always #20 us_clk = ~us_clk;

	// One full run of the accumulator, applied to the reference state
	function automatic void yaw_model(input int throttle, input int stick, input int imu,
		input bit bypass, output int exp_target, output int exp_error, output bit exp_window);
		bit idle;
		int norm;
		int sum;
		int target;
		int wrapped;
		int limited;
		idle = (throttle < yaw_pkg::THROTTLE_IDLE_MAX);
		if (idle) begin
			model_neutral = stick;
		end
		norm = stick - model_neutral;
		exp_window = !idle && !(norm > -yaw_pkg::NEUTRAL_HALF_WINDOW &&
			norm < yaw_pkg::NEUTRAL_HALF_WINDOW);
		sum = model_track + norm;
		if (idle) begin
			model_track = imu * 4;
		end else if (exp_window) begin
			if (sum > yaw_pkg::ANGLE_360_SCALED) begin
				model_track = sum - yaw_pkg::ANGLE_360_SCALED;
			end else if (sum < 0) begin
				model_track = sum + yaw_pkg::ANGLE_360_SCALED;
			end else begin
				model_track = sum;
			end
		end
		target = idle ? imu : (model_track >>> 2);
		// Shortest way round through the 0/360 crossing
		if (idle) begin
			wrapped = 0;
		end else if (target > yaw_pkg::ANGLE_270 && imu < yaw_pkg::ANGLE_90) begin
			wrapped = -(yaw_pkg::ANGLE_360 - target + imu);
		end else if (imu > yaw_pkg::ANGLE_270 && target < yaw_pkg::ANGLE_90) begin
			wrapped = yaw_pkg::ANGLE_360 - imu + target;
		end else begin
			wrapped = target - imu;
		end
		if (model_prev_error >= 1440 && wrapped <= -1440) begin
			limited = 1440;
		end else if (model_prev_error <= -1440 && wrapped >= 1440) begin
			limited = -1440;
		end else if (wrapped < model_prev_error - 50) begin
			limited = model_prev_error - 50;
		end else if (wrapped > model_prev_error + 50) begin
			limited = model_prev_error + 50;
		end else begin
			limited = wrapped;
		end
		model_prev_error = limited;
		if (bypass) begin
			exp_target = stick;
			exp_error = 0;
		end else begin
			exp_target = target;
			exp_error = (limited > 1440) ? 1440 : ((limited < -1440) ? -1440 : limited);
		end
	endfunction

	task automatic queue_expected(input int throttle, input int stick, input int imu,
		input bit bypass);
		int et;
		int ee;
		bit ew;
		yaw_model(throttle, stick, imu, bypass, et, ee, ew);
		exp_target_q.push_back(et);
		exp_error_q.push_back(ee);
		exp_window_q.push_back(ew);
	endtask

	task automatic wait_complete();
		int waited;
		waited = 0;
		@(negedge us_clk);
		while (!complete_signal) begin
			waited++;
			if (waited > RUN_TIMEOUT) begin
				$display("No complete pulse within %0d cycles of start at %0t", RUN_TIMEOUT,
					$time);
				$display("RESULT: FAIL");
				$finish;
			end
			@(negedge us_clk);
		end
	endtask

	// Called 2 ns after a rising edge, returns at the same point
	task automatic apply_run(input int throttle, input int stick, input int imu,
		input bit bypass);
		queue_expected(throttle, stick, imu, bypass);
		throttle_pwm_value_input = throttle[7:0];
		yaw_pwm_value_input = stick[7:0];
		yaw_angle_imu = imu[15:0];
		yaac_enable_n = bypass;
		start_signal = 1'b1;
		@(posedge us_clk);
		#2;
		start_signal = 1'b0;
		wait_complete();
		@(posedge us_clk);
		#2;
	endtask

	task automatic restart_during_run(input int throttle, input int stick, input int imu);
		int count_before;
		count_before = complete_count;
		queue_expected(throttle, stick, imu, 1'b0);
		queue_expected(throttle, stick, imu, 1'b0);
		throttle_pwm_value_input = throttle[7:0];
		yaw_pwm_value_input = stick[7:0];
		yaw_angle_imu = imu[15:0];
		yaac_enable_n = 1'b0;
		start_signal = 1'b1;
		@(posedge us_clk);
		#2;
		start_signal = 1'b0;
		// Second start is sampled in the last cycle of the run, while active is high
		repeat (12) @(posedge us_clk);
		#2;
		start_signal = 1'b1;
		@(posedge us_clk);
		#2;
		start_signal = 1'b0;
		wait_complete();
		wait_complete();
		repeat (RUN_TIMEOUT) @(posedge us_clk);
		#2;
		check_count++;
		if (complete_count != count_before + 2) begin
			$display("ERROR at %0t: %0d complete pulses for two starts", $time,
				complete_count - count_before);
			error_count++;
		end
	endtask

	// Outputs are stable mid-cycle while complete is high
	always @(negedge us_clk) begin : compare_outputs
		int et;
		int ee;
		bit ew;
		if (resetn && active_signal) begin
			active_cycles++;
		end
		if (resetn && complete_signal) begin
			complete_count++;
			check_count++;
			if (active_cycles != ACTIVE_CYCLES) begin
				$display("ERROR at %0t: active high for %0d cycles, expected %0d", $time,
					active_cycles, ACTIVE_CYCLES);
				error_count++;
			end
			active_cycles = 0;
			if (exp_target_q.size() == 0) begin
				$display("Complete pulse at %0t with no run pending", $time);
				error_count++;
			end else begin
				et = exp_target_q.pop_front();
				ee = exp_error_q.pop_front();
				ew = exp_window_q.pop_front();
				check_count += 4;
				if (body_yaw_angle_target != et) begin
					$display("ERROR at %0t: target %0d, expected %0d", $time,
						body_yaw_angle_target, et);
					error_count++;
				end
				if (yaw_angle_error_out != ee) begin
					$display("ERROR at %0t: error out %0d, expected %0d", $time,
						yaw_angle_error_out, ee);
					error_count++;
				end
				if (yaw_stick_out_of_neutral_window != ew) begin
					$display("ERROR at %0t: window flag %0b, expected %0b", $time,
						yaw_stick_out_of_neutral_window, ew);
					error_count++;
				end
				if (yaw_angle_error_out > 1440 || yaw_angle_error_out < -1440) begin
					$display("ERROR at %0t: error out %0d beyond 90 degrees", $time,
						yaw_angle_error_out);
					error_count++;
				end
			end
		end
	end

	always @(posedge us_clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int stick;
		int imu;
		int throttle;
		bit bypass;
		void'($urandom(32'hb8fad43d));
		error_count = 0;
		check_count = 0;
		complete_count = 0;
		cycle_count = 0;
		active_cycles = 0;
		model_neutral = 0;
		model_track = 0;
		model_prev_error = 0;
		resetn = 1'b0;
		start_signal = 1'b0;
		yaac_enable_n = 1'b0;
		throttle_pwm_value_input = '0;
		yaw_pwm_value_input = '0;
		yaw_angle_imu = '0;
		repeat (3) @(posedge us_clk);
		#2;
		resetn = 1'b1;
		repeat (2) @(posedge us_clk);
		#2;

		// Idle throttle, target follows the IMU
		for (int i = 0; i < 5; i++) begin
			apply_run(0, 128, 300 + i * 900, 1'b0);
		end

		// Neutral learned at 130, then small and large deflections
		apply_run(0, 130, 1000, 1'b0);
		apply_run(100, 128, 1000, 1'b0);
		apply_run(100, 132, 1000, 1'b0);
		apply_run(100, 130, 1000, 1'b0);
		repeat (3) apply_run(100, 200, 1000, 1'b0);

		// Wrap through 360 and then through 0
		apply_run(0, 130, 5740, 1'b0);
		repeat (6) apply_run(100, 255, 5740, 1'b0);
		apply_run(0, 130, 20, 1'b0);
		repeat (6) apply_run(100, 0, 20, 1'b0);

		// IMU near the 0/360 crossing
		repeat (20) begin
			stick = $urandom_range(255);
			imu = ($urandom_range(1) == 1) ? $urandom_range(199) : 5560 + $urandom_range(199);
			apply_run(100, stick, imu, 1'b0);
		end

		// Target held at 180 degrees drives the error past the rail, then reversed
		apply_run(0, 130, 2880, 1'b0);
		repeat (45) apply_run(100, 130, 5740, 1'b0);
		repeat (2) apply_run(100, 130, 0, 1'b0);

		repeat (5) begin
			stick = $urandom_range(255);
			imu = $urandom_range(5759);
			apply_run(100, stick, imu, 1'b1);
		end

		restart_during_run(100, 180, 2000);

		repeat (200) begin
			throttle = $urandom_range(40);
			stick = $urandom_range(255);
			imu = $urandom_range(5759);
			bypass = ($urandom_range(7) == 0);
			apply_run(throttle, stick, imu, bypass);
		end

		if (exp_target_q.size() != 0) begin
			$display("%0d expected results were never compared", exp_target_q.size());
			error_count++;
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== yaw_angle_accumulator.f ====
hdl/yaw_pkg.sv
hdl/yaw_sequencer.sv
hdl/yaw_stick_tracker.sv
hdl/yaw_error_limiter.sv
hdl/yaw_angle_accumulator.sv
test/yaw_angle_accumulator_assert.sv
test/tb_yaw_angle_accumulator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_yaw_angle_accumulator \
	-f yaw_angle_accumulator.f > build.log 2>&1 &&
	./obj_dir/Vtb_yaw_angle_accumulator > sim.log 2>&1 ||
	echo "Build or simulation stopped early" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
